// ==== Bender.yml ====
package:
  name: pc_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pc_ctrl_pkg.sv
      - hdl/pc_bus_pkg.sv
      - hdl/pc_ctrl.sv
      - hdl/pc_byte.sv
      - hdl/pc_bus_drive.sv
      - hdl/pc_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/pc_clk_gen.sv
      - dv/pc_unit_tb.sv

// ==== dv/pc_clk_gen.sv ====
`timescale 1ns/1ps

module pc_clk_gen #(
	parameter int PERIOD     = 4,	// ns
	parameter int RST_CYCLES = 4
) (
	output logic phi2,
	output logic arst_n
);

	initial begin
		phi2 = 1'b0;
		forever #(PERIOD / 2) phi2 = ~phi2;
	end

	// Release 1 ns after an edge, away from the sampling point
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge phi2);
		#1;
		arst_n = 1'b1;
	end

endmodule

// ==== dv/pc_unit_tb.sv ====
`timescale 1ns/1ps
`include "pc_macros.svh"

module pc_unit_tb;

	localparam int TEST_CYCLES = 200;	// Budget for all tests together
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
	localparam int SEQ_LEN     = 40;

	logic                    phi2;
	logic                    arst_n;
	pc_ctrl_pkg::pc_op_e     op;
	pc_bus_pkg::pc_bus_in_t  bus_in;
	pc_bus_pkg::pc_bus_out_t bus_out;
	logic [`PC_W-1:0]        pc;

	logic [`PC_W-1:0] model_pc;	// Expected PC before the current op
	integer           seed;
	int               errors;
	int               checks;
	int               tests_ok;
	int               tests_bad;
	int               cycles;

	pc_clk_gen #(.PERIOD(4), .RST_CYCLES(4)) pc_clk_gen_i (
		.phi2   (phi2),
		.arst_n (arst_n)
	);

	pc_unit pc_unit_i (
		.phi2    (phi2),
		.arst_n  (arst_n),
		.op      (op),
		.bus_in  (bus_in),
		.bus_out (bus_out),
		.pc      (pc)
	);

	// Next PC by the per-byte rule of bus or own value plus the increment
	function automatic logic [`PC_W-1:0] next_pc(input logic [`PC_W-1:0] cur,
			input pc_ctrl_pkg::pc_op_e op_v, input pc_bus_pkg::pc_bus_in_t bus_v);
		logic load_l;
		logic load_h;
		logic inc;
		logic [`PC_W-1:0] base;
		load_l = op_v inside {pc_ctrl_pkg::PC_LOAD_ADR, pc_ctrl_pkg::PC_LOAD_ADR_INC,
			pc_ctrl_pkg::PC_LOAD_LOW};
		load_h = op_v inside {pc_ctrl_pkg::PC_LOAD_ADR, pc_ctrl_pkg::PC_LOAD_ADR_INC};
		inc    = op_v inside {pc_ctrl_pkg::PC_INC, pc_ctrl_pkg::PC_FETCH,
			pc_ctrl_pkg::PC_LOAD_ADR_INC};
		base[15:8] = load_h ? bus_v.adh : cur[15:8];
		base[7:0]  = load_l ? bus_v.adl : cur[7:0];
		return base + {15'd0, inc};	// Wraps at 16 bits
	endfunction

	// Bus outputs expected for the current PC and op
	function automatic pc_bus_pkg::pc_bus_out_t exp_bus(input logic [`PC_W-1:0] cur,
			input pc_ctrl_pkg::pc_op_e op_v);
		pc_bus_pkg::pc_bus_out_t b;
		b = '0;
		if (op_v == pc_ctrl_pkg::PC_FETCH) begin
			b.adl    = cur[7:0];
			b.adh    = cur[15:8];
			b.adl_en = 1'b1;
			b.adh_en = 1'b1;
		end else if (op_v == pc_ctrl_pkg::PC_PUSH_LOW) begin
			b.db    = cur[7:0];
			b.db_en = 1'b1;
		end else if (op_v == pc_ctrl_pkg::PC_PUSH_HIGH) begin
			b.db    = cur[15:8];
			b.db_en = 1'b1;
		end
		return b;
	endfunction

	function automatic pc_bus_pkg::pc_bus_in_t rand_bus();
		logic [31:0] r;
		r = $random(seed);
		return r[23:0];
	endfunction

	task automatic check_pc(input logic [`PC_W-1:0] got, input logic [`PC_W-1:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s pc got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_bus(input pc_bus_pkg::pc_bus_out_t got,
			input pc_bus_pkg::pc_bus_out_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s bus got %h/%h/%h %b%b%b exp %h/%h/%h %b%b%b",
				$time, msg, got.adl, got.adh, got.db, got.adl_en, got.adh_en, got.db_en,
				exp.adl, exp.adh, exp.db, exp.adl_en, exp.adh_en, exp.db_en);
		end
	endtask

	// Drive one op, check against the model and advance the model
	task automatic run_op(input pc_ctrl_pkg::pc_op_e op_v,
			input pc_bus_pkg::pc_bus_in_t bus_v, input string tag);
		@(posedge phi2);
		#1;
		op     = op_v;
		bus_in = bus_v;
		#1;
		check_pc(pc, model_pc, tag);
		check_bus(bus_out, exp_bus(model_pc, op_v), tag);
		model_pc = next_pc(model_pc, op_v, bus_v);
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			tests_ok++;
			$display("Test %s: ok", name);
		end else begin
			tests_bad++;
			$display("Test %s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		@(posedge phi2);
		#1;
		check_pc(pc, `PC_RESET_VEC, "reset: load op held in reset");
		check_bus(bus_out, '0, "reset: buses during reset");
		wait (arst_n === 1'b1);
		op       = pc_ctrl_pkg::PC_HOLD;	// Set in the step of the release
		model_pc = `PC_RESET_VEC;
		run_op(pc_ctrl_pkg::PC_HOLD, '0, "reset: hold");
		run_op(pc_ctrl_pkg::PC_HOLD, '0, "reset: hold");
		check_pc(pc, 16'hFFFC, "reset: vector");
		report_test("reset", err0);
	endtask

	task automatic test_increment();
		logic [`PC_W-1:0] starts [3];
		logic [`PC_W-1:0] ends [3];
		int err0;
		err0   = errors;
		starts = '{16'h00FF, 16'h0FFF, 16'hFFFF};
		ends   = '{16'h0100, 16'h1000, 16'h0000};
		for (int i = 0; i < 3; i++) begin
			run_op(pc_ctrl_pkg::PC_LOAD_ADR, {starts[i][7:0], starts[i][15:8], 8'h00},
				"inc: load");
			run_op(pc_ctrl_pkg::PC_INC, '0, "inc: step");
			run_op(pc_ctrl_pkg::PC_HOLD, '0, "inc: hold");
			check_pc(pc, ends[i], "inc: carry result");
		end
		report_test("increment", err0);
	endtask

	task automatic test_fetch();
		int err0;
		err0 = errors;
		run_op(pc_ctrl_pkg::PC_LOAD_ADR, {8'hFE, 8'h20, 8'h00}, "fetch: load");
		repeat (3) run_op(pc_ctrl_pkg::PC_FETCH, '0, "fetch");	// Crosses into page 21
		run_op(pc_ctrl_pkg::PC_HOLD, '0, "fetch: hold");
		check_pc(pc, 16'h2101, "fetch: final address");
		report_test("fetch", err0);
	endtask

	task automatic test_loads();
		pc_bus_pkg::pc_bus_in_t b;
		int err0;
		err0 = errors;
		for (int i = 0; i < 4; i++) begin
			run_op(pc_ctrl_pkg::PC_LOAD_ADR, rand_bus(), "load: adr");
			b = rand_bus();
			if (i == 0) b.adl = 8'hFF;	// Carry into PCH
			if (i == 1) begin
				b.adl = 8'hFF;	// Full wrap
				b.adh = 8'hFF;
			end
			run_op(pc_ctrl_pkg::PC_LOAD_ADR_INC, b, "load: adr inc");
			run_op(pc_ctrl_pkg::PC_LOAD_LOW, rand_bus(), "load: low");
			run_op(pc_ctrl_pkg::PC_HOLD, rand_bus(), "load: hold");
		end
		report_test("loads", err0);
	endtask

	task automatic test_push();
		int err0;
		err0 = errors;
		run_op(pc_ctrl_pkg::PC_LOAD_ADR, {8'h5A, 8'hC3, 8'h00}, "push: load");
		run_op(pc_ctrl_pkg::PC_PUSH_LOW, rand_bus(), "push: low");
		run_op(pc_ctrl_pkg::PC_PUSH_HIGH, rand_bus(), "push: high");
		run_op(pc_ctrl_pkg::PC_HOLD, '0, "push: hold");
		check_pc(pc, 16'hC35A, "push: pc unchanged");
		report_test("push", err0);
	endtask

	task automatic test_sequence();
		logic [31:0] r;
		int err0;
		err0 = errors;
		for (int i = 0; i < SEQ_LEN; i++) begin
			r = $random(seed);
			run_op(pc_ctrl_pkg::pc_op_e'(r[2:0]), rand_bus(), "seq");
		end
		run_op(pc_ctrl_pkg::PC_HOLD, '0, "seq: hold");
		report_test("sequence", err0);
	endtask

	initial begin
		op        = pc_ctrl_pkg::PC_LOAD_ADR;	// Must be ignored in reset
		bus_in    = {8'h34, 8'h12, 8'h00};
		model_pc  = `PC_RESET_VEC;
		seed      = 1370;
		errors    = 0;
		checks    = 0;
		tests_ok  = 0;
		tests_bad = 0;
		test_reset();
		test_increment();
		test_fetch();
		test_loads();
		test_push();
		test_sequence();
		$display("Summary: %0d tests ok, %0d tests failed, %0d checks, %0d errors",
			tests_ok, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge phi2);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/pc_ctrl_pkg.sv
hdl/pc_bus_pkg.sv
hdl/pc_ctrl.sv
hdl/pc_byte.sv
hdl/pc_bus_drive.sv
hdl/pc_unit.sv
dv/pc_clk_gen.sv
dv/pc_unit_tb.sv

// ==== hdl/pc_bus_drive.sv ====
`timescale 1ns/1ps
`include "pc_macros.svh"

module pc_bus_drive (
	input  pc_ctrl_pkg::pc_strobe_t strobe,
	input  logic [`PC_W-1:0]        pc,
	input  logic                    phi2,	// Assertions only
	input  logic                    arst_n,
	output pc_bus_pkg::pc_bus_out_t bus_out
);

	logic [`PC_BYTE_W-1:0] pcl;
	logic [`PC_BYTE_W-1:0] pch;

	assign pcl = pc[`PC_BYTE_W-1:0];
	assign pch = pc[`PC_W-1:`PC_BYTE_W];

	always_comb begin
		bus_out = pc_bus_pkg::PC_BUS_IDLE;	// Undriven buses read zero

		if (strobe.pcl_adl) begin
			bus_out.adl    = pcl;
			bus_out.adl_en = 1'b1;
		end

		if (strobe.pch_adh) begin
			bus_out.adh    = pch;
			bus_out.adh_en = 1'b1;
		end

		// PCL has priority on DB
		if (strobe.pcl_db) begin
			bus_out.db    = pcl;
			bus_out.db_en = 1'b1;
		end else if (strobe.pch_db) begin
			bus_out.db    = pch;
			bus_out.db_en = 1'b1;
		end
	end

	// Both bytes on DB would short the bus on silicon
	assert property (@(posedge phi2) disable iff (!arst_n)
		!(strobe.pcl_db && strobe.pch_db))
		else $error("pc_bus_drive PCL and PCH both on DB");

	// A push never puts the address out in the same cycle
	assert property (@(posedge phi2) disable iff (!arst_n)
		bus_out.db_en |-> !(bus_out.adl_en || bus_out.adh_en))
		else $error("pc_bus_drive DB and address driven together");

endmodule

// ==== hdl/pc_bus_pkg.sv ====
`include "pc_macros.svh"

package pc_bus_pkg;

	// Values seen on the internal buses this cycle
	typedef struct packed {
		logic [`PC_BYTE_W-1:0] adl;	// Address low
		logic [`PC_BYTE_W-1:0] adh;	// Address high
		logic [`PC_BYTE_W-1:0] db;	// Data
	} pc_bus_in_t;

	// What the PC puts on the buses
	// A value is only meaningful while its enable is set
	typedef struct packed {
		logic [`PC_BYTE_W-1:0] adl;
		logic [`PC_BYTE_W-1:0] adh;
		logic [`PC_BYTE_W-1:0] db;
		logic                  adl_en;	// PCL on ADL
		logic                  adh_en;	// PCH on ADH
		logic                  db_en;	// PCL or PCH on DB
	} pc_bus_out_t;

	// Nothing driven
	localparam pc_bus_out_t PC_BUS_IDLE = '0;

endpackage

// ==== hdl/pc_byte.sv ====
`timescale 1ns/1ps
`include "pc_macros.svh"

module pc_byte #(
	parameter logic [`PC_BYTE_W-1:0] RESET_VAL = 8'hFC
) (
	input  logic                  phi2,
	input  logic                  arst_n,
	input  logic                  load,	// Take bus_val
	input  logic                  hold,	// Take own value
	input  logic [`PC_BYTE_W-1:0] bus_val,
	input  logic                  carry_in,
	output logic [`PC_BYTE_W-1:0] val,
	output logic                  carry_out
);

	logic [`PC_BYTE_W-1:0] base;	// Like the PCLS/PCHS latch
	logic [`PC_NIB_W-1:0]  base_lo;
	logic [`PC_NIB_W-1:0]  base_hi;
	logic                  lo_ones;	// Low nibble all ones
	logic                  hi_ones;
	logic                  carry_hi;	// Carry into the upper nibble
	logic [`PC_NIB_W-1:0]  sum_lo;
	logic [`PC_NIB_W-1:0]  sum_hi;
	logic [`PC_BYTE_W-1:0] next_val;

	// Load and keep select as an AND-OR mux
	assign base = ({`PC_BYTE_W{load}} & bus_val) |
	              ({`PC_BYTE_W{hold}} & val);

	assign base_lo = base[`PC_NIB_W-1:0];
	assign base_hi = base[`PC_BYTE_W-1:`PC_NIB_W];

	assign lo_ones = &base_lo;
	assign hi_ones = &base_hi;

	// Upper nibble carry looks ahead over the low nibble
	assign carry_hi  = carry_in & lo_ones;
	assign carry_out = carry_hi & hi_ones;	// Base was FF and carry_in set

	assign sum_lo = base_lo + {{(`PC_NIB_W-1){1'b0}}, carry_in};
	assign sum_hi = base_hi + {{(`PC_NIB_W-1){1'b0}}, carry_hi};

	assign next_val = {sum_hi, sum_lo};

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			val <= RESET_VAL;
		end else begin
			val <= next_val;
		end
	end

	// The decoder must pick exactly one source for this byte
	assert property (@(posedge phi2) disable iff (!arst_n)
		load ^ hold)
		else $error("pc_byte load=%b hold=%b", load, hold);

endmodule

// ==== hdl/pc_ctrl.sv ====
`timescale 1ns/1ps

module pc_ctrl (
	input  logic                   phi2,	// Only for the op check
	input  pc_ctrl_pkg::pc_op_e    op,
	output pc_ctrl_pkg::pc_strobe_t strobe
);

	pc_ctrl_pkg::pc_strobe_t dec;

	always_comb begin
		dec = pc_ctrl_pkg::PC_STROBE_IDLE;	// Keep both bytes, drive nothing
		unique case (op)
			pc_ctrl_pkg::PC_HOLD: begin
				dec = pc_ctrl_pkg::PC_STROBE_IDLE;
			end
			pc_ctrl_pkg::PC_INC: begin
				dec.ipc = 1'b1;
			end
			pc_ctrl_pkg::PC_FETCH: begin
				dec.ipc     = 1'b1;	// Old address goes out before the step
				dec.pcl_adl = 1'b1;
				dec.pch_adh = 1'b1;
			end
			pc_ctrl_pkg::PC_LOAD_ADR: begin
				dec.adl_pcl = 1'b1;
				dec.pcl_pcl = 1'b0;
				dec.adh_pch = 1'b1;
				dec.pch_pch = 1'b0;
			end
			pc_ctrl_pkg::PC_LOAD_ADR_INC: begin
				dec.ipc     = 1'b1;	// Carry formed on the loaded value
				dec.adl_pcl = 1'b1;
				dec.pcl_pcl = 1'b0;
				dec.adh_pch = 1'b1;
				dec.pch_pch = 1'b0;
			end
			pc_ctrl_pkg::PC_LOAD_LOW: begin
				dec.adl_pcl = 1'b1;	// PCH keeps its value as for a branch in page
				dec.pcl_pcl = 1'b0;
			end
			pc_ctrl_pkg::PC_PUSH_LOW: begin
				dec.pcl_db = 1'b1;
			end
			pc_ctrl_pkg::PC_PUSH_HIGH: begin
				dec.pch_db = 1'b1;
			end
			default: begin
				dec = pc_ctrl_pkg::PC_STROBE_IDLE;
			end
		endcase
	end

	assign strobe = dec;

	// An unknown code would leave the load/keep pair undefined
	assert property (@(posedge phi2)
		!$isunknown(op) && op inside {
			pc_ctrl_pkg::PC_HOLD, pc_ctrl_pkg::PC_INC,
			pc_ctrl_pkg::PC_FETCH, pc_ctrl_pkg::PC_LOAD_ADR,
			pc_ctrl_pkg::PC_LOAD_ADR_INC, pc_ctrl_pkg::PC_LOAD_LOW,
			pc_ctrl_pkg::PC_PUSH_LOW, pc_ctrl_pkg::PC_PUSH_HIGH
		})
		else $error("pc_ctrl illegal op %0h", op);

endmodule

// ==== hdl/pc_ctrl_pkg.sv ====
package pc_ctrl_pkg;

	// One operation code per cycle
	typedef enum logic [2:0] {
		PC_HOLD         = 3'd0,	// Keep PC
		PC_INC          = 3'd1,	// PC + 1
		PC_FETCH        = 3'd2,	// PC on ADL/ADH then PC + 1
		PC_LOAD_ADR     = 3'd3,	// PCL <- ADL, PCH <- ADH
		PC_LOAD_ADR_INC = 3'd4,	// Load from ADL/ADH plus one
		PC_LOAD_LOW     = 3'd5,	// PCL <- ADL only
		PC_PUSH_LOW     = 3'd6,	// PCL on DB
		PC_PUSH_HIGH    = 3'd7	// PCH on DB
	} pc_op_e;

	// Control strobes of the PC
	// Load and keep strobes of a byte are exclusive
	typedef struct packed {
		logic ipc;	// Increment
		logic adl_pcl;	// PCL loads from ADL
		logic pcl_pcl;	// PCL keeps its value
		logic adh_pch;	// PCH loads from ADH
		logic pch_pch;	// PCH keeps its value
		logic pcl_adl;	// PCL drives ADL
		logic pch_adh;	// PCH drives ADH
		logic pcl_db;	// PCL drives DB
		logic pch_db;	// PCH drives DB
	} pc_strobe_t;

	// Strobe set of an idle cycle
	localparam pc_strobe_t PC_STROBE_IDLE = '{
		ipc: 1'b0, adl_pcl: 1'b0, pcl_pcl: 1'b1,
		adh_pch: 1'b0, pch_pch: 1'b1,
		pcl_adl: 1'b0, pch_adh: 1'b0,
		pcl_db: 1'b0, pch_db: 1'b0
	};

endpackage

// ==== hdl/pc_macros.svh ====
`ifndef PC_MACROS_SVH
`define PC_MACROS_SVH

// Width of one internal bus and of one PC byte
`define PC_BYTE_W 8

// Width of the whole program counter
`define PC_W 16

// Value loaded into PCH:PCL while arst_n is low
`define PC_RESET_VEC 16'hFFFC

// Nibble width used by the carry lookahead
`define PC_NIB_W 4

`endif

// ==== hdl/pc_unit.sv ====
`timescale 1ns/1ps
`include "pc_macros.svh"

module pc_unit (
	input  logic                    phi2,
	input  logic                    arst_n,
	input  pc_ctrl_pkg::pc_op_e     op,
	input  pc_bus_pkg::pc_bus_in_t  bus_in,
	output pc_bus_pkg::pc_bus_out_t bus_out,
	output logic [`PC_W-1:0]        pc	// Debug view of PCH:PCL
);

	localparam logic [`PC_W-1:0] RST_VEC = `PC_RESET_VEC;

	pc_ctrl_pkg::pc_strobe_t strobe;
	logic                    pcl_carry;	// PCLC into the high byte

	pc_ctrl pc_ctrl_i (
		.phi2   (phi2),
		.op     (op),
		.strobe (strobe)
	);

	pc_byte #(
		.RESET_VAL (RST_VEC[`PC_BYTE_W-1:0])
	) pcl_i (
		.phi2      (phi2),
		.arst_n    (arst_n),
		.load      (strobe.adl_pcl),
		.hold      (strobe.pcl_pcl),
		.bus_val   (bus_in.adl),
		.carry_in  (strobe.ipc),
		.val       (pc[`PC_BYTE_W-1:0]),
		.carry_out (pcl_carry)
	);

	// Top carry is dropped so FFFF wraps to 0000
	pc_byte #(
		.RESET_VAL (RST_VEC[`PC_W-1:`PC_BYTE_W])
	) pch_i (
		.phi2      (phi2),
		.arst_n    (arst_n),
		.load      (strobe.adh_pch),
		.hold      (strobe.pch_pch),
		.bus_val   (bus_in.adh),
		.carry_in  (pcl_carry),
		.val       (pc[`PC_W-1:`PC_BYTE_W]),
		.carry_out ()
	);

	pc_bus_drive pc_bus_drive_i (
		.strobe  (strobe),
		.pc      (pc),
		.phi2    (phi2),
		.arst_n  (arst_n),
		.bus_out (bus_out)
	);

endmodule
